/* common/bp_pkg.sv */
package bp_pkg;

    // branch instruction address
    typedef logic [31:0] pc_t;

    // one 2-bit saturating counter
    // bit 1 set means taken, or prefer gselect in the chooser
    typedef logic [1:0] ctr_t;

    // apb data and the statistics counters
    typedef logic [31:0] word_t;

    // apb byte address
    typedef logic [7:0] paddr_t;

    // prediction source select
    // encoding 3 is not listed and behaves as tournament
    typedef enum logic [1:0] {
        MODE_TOURNAMENT = 2'd0,
        MODE_BIMODAL    = 2'd1,
        MODE_GSELECT    = 2'd2
    } bp_mode_e;

    // weakly not-taken
    localparam ctr_t CTR_RESET = 2'b01;

    // register byte offsets
    localparam paddr_t REG_CTRL     = 8'h00;
    localparam paddr_t REG_BRANCHES = 8'h04;
    localparam paddr_t REG_MISPRED  = 8'h08;
    localparam paddr_t REG_CLEAR    = 8'h0C;

endpackage : bp_pkg

/* bp_core/counter_table.sv */
`timescale 1ns/1ps

module counter_table #(
    parameter int IDX_W = 8
) (
    input  logic               clk,
    input  logic               rst,

    input  logic [IDX_W-1:0]   rd_idx_i,
    output bp_pkg::ctr_t       rd_ctr_o,

    input  logic               wr_en_i,
    input  logic [IDX_W-1:0]   wr_idx_i,
    input  logic               wr_taken_i,
    output bp_pkg::ctr_t       wr_ctr_o
);

    localparam int DEPTH = 1 << IDX_W;

    bp_pkg::ctr_t ctr_q [DEPTH];
    bp_pkg::ctr_t ctr_next;

    // both ports read the array asynchronously
    assign rd_ctr_o = ctr_q[rd_idx_i];
    assign wr_ctr_o = ctr_q[wr_idx_i];

    // one step toward the outcome, saturating at 0 and 3
    always_comb begin
        ctr_next = wr_ctr_o;
        if (wr_taken_i) begin
            if (wr_ctr_o != 2'b11) begin
                ctr_next = wr_ctr_o + 2'd1;
            end
        end else begin
            if (wr_ctr_o != 2'b00) begin
                ctr_next = wr_ctr_o - 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                ctr_q[i] <= bp_pkg::CTR_RESET;
            end
        end else if (wr_en_i) begin
            ctr_q[wr_idx_i] <= ctr_next;
        end
    end

endmodule : counter_table

/* bp_core/tournament_predictor.sv */
`timescale 1ns/1ps

module tournament_predictor #(
    parameter int IDX_W  = 8,
    parameter int HIST_W = 4
) (
    input  logic               clk,
    input  logic               rst,

    input  bp_pkg::bp_mode_e   mode_i,

    input  bp_pkg::pc_t        pred_pc_i,
    output logic               pred_taken_o,

    input  logic               upd_valid_i,
    input  bp_pkg::pc_t        upd_pc_i,
    input  logic               upd_taken_i
);

    typedef logic [IDX_W-1:0]  idx_t;
    typedef logic [HIST_W-1:0] hist_t;

    hist_t          hist_q;
    logic [HIST_W:0] hist_shift;

    idx_t           pred_bim_idx;
    idx_t           pred_gs_idx;
    idx_t           upd_bim_idx;
    idx_t           upd_gs_idx;

    bp_pkg::ctr_t   pred_bim_ctr;
    bp_pkg::ctr_t   pred_gs_ctr;
    bp_pkg::ctr_t   pred_cho_ctr;
    bp_pkg::ctr_t   upd_bim_ctr;
    bp_pkg::ctr_t   upd_gs_ctr;

    logic           cho_train;
    logic           gs_correct;

    // word-aligned pc bits select the entry
    assign pred_bim_idx = pred_pc_i[IDX_W+1:2];
    assign upd_bim_idx  = upd_pc_i[IDX_W+1:2];

    // gselect keeps fewer pc bits and appends the history
    assign pred_gs_idx  = {pred_pc_i[IDX_W-HIST_W+1:2], hist_q};
    assign upd_gs_idx   = {upd_pc_i[IDX_W-HIST_W+1:2], hist_q};

    counter_table #(
        .IDX_W      (IDX_W)
    ) bimodal_tbl (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (pred_bim_idx),
        .rd_ctr_o   (pred_bim_ctr),
        .wr_en_i    (upd_valid_i),
        .wr_idx_i   (upd_bim_idx),
        .wr_taken_i (upd_taken_i),
        .wr_ctr_o   (upd_bim_ctr)
    );

    counter_table #(
        .IDX_W      (IDX_W)
    ) gselect_tbl (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (pred_gs_idx),
        .rd_ctr_o   (pred_gs_ctr),
        .wr_en_i    (upd_valid_i),
        .wr_idx_i   (upd_gs_idx),
        .wr_taken_i (upd_taken_i),
        .wr_ctr_o   (upd_gs_ctr)
    );

    // chooser only learns when the two components disagree
    assign cho_train  = upd_valid_i && (upd_bim_ctr[1] != upd_gs_ctr[1]);
    assign gs_correct = (upd_gs_ctr[1] == upd_taken_i);

    counter_table #(
        .IDX_W      (IDX_W)
    ) chooser_tbl (
        .clk        (clk),
        .rst        (rst),
        .rd_idx_i   (pred_bim_idx),
        .rd_ctr_o   (pred_cho_ctr),
        .wr_en_i    (cho_train),
        .wr_idx_i   (upd_bim_idx),
        .wr_taken_i (gs_correct),
        .wr_ctr_o   ()
    );

    always_comb begin
        case (mode_i)
            bp_pkg::MODE_BIMODAL: pred_taken_o = pred_bim_ctr[1];
            bp_pkg::MODE_GSELECT: pred_taken_o = pred_gs_ctr[1];
            default:              pred_taken_o = pred_cho_ctr[1] ? pred_gs_ctr[1]
                                                                 : pred_bim_ctr[1];
        endcase
    end

    // newest outcome enters at bit 0
    assign hist_shift = {hist_q, upd_taken_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            hist_q <= '0;
        end else if (upd_valid_i) begin
            hist_q <= hist_shift[HIST_W-1:0];
        end
    end

endmodule : tournament_predictor

/* rtl/bp_csr.sv */
`timescale 1ns/1ps

module bp_csr (
    input  logic               clk,
    input  logic               rst,

    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  bp_pkg::paddr_t     paddr_i,
    input  bp_pkg::word_t      pwdata_i,
    output bp_pkg::word_t      prdata_o,
    output logic               pready_o,

    output bp_pkg::bp_mode_e   mode_o,

    input  logic               upd_valid_i,
    input  logic               upd_taken_i,
    input  logic               upd_pred_i
);

    logic           access;
    logic           wr_en;
    logic           mode_we;
    logic           clr;

    logic [1:0]     mode_q;
    bp_pkg::word_t  branches_q;
    bp_pkg::word_t  mispred_q;

    // no wait states
    assign access   = psel_i && penable_i;
    assign pready_o = access;
    assign wr_en    = access && pwrite_i;

    assign mode_we  = wr_en && (paddr_i == bp_pkg::REG_CTRL);
    assign clr      = wr_en && (paddr_i == bp_pkg::REG_CLEAR) && pwdata_i[0];

    // raw field kept so that mode 3 reads back as written
    assign mode_o   = bp_pkg::bp_mode_e'(mode_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_q <= bp_pkg::MODE_TOURNAMENT;
        end else if (mode_we) begin
            mode_q <= pwdata_i[1:0];
        end
    end

    // statistics
    // clear wins over an update in the same cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            branches_q <= '0;
            mispred_q  <= '0;
        end else if (clr) begin
            branches_q <= '0;
            mispred_q  <= '0;
        end else if (upd_valid_i) begin
            branches_q <= branches_q + 32'd1;
            if (upd_taken_i != upd_pred_i) begin
                mispred_q <= mispred_q + 32'd1;
            end
        end
    end

    // read mux
    // unmapped offsets return zero
    always_comb begin
        prdata_o = '0;
        if (psel_i && !pwrite_i) begin
            case (paddr_i)
                bp_pkg::REG_CTRL:     prdata_o = {30'd0, mode_q};
                bp_pkg::REG_BRANCHES: prdata_o = branches_q;
                bp_pkg::REG_MISPRED:  prdata_o = mispred_q;
                default:              prdata_o = '0;
            endcase
        end
    end

endmodule : bp_csr

/* rtl/bp_top.sv */
`timescale 1ns/1ps

module bp_top #(
    parameter int IDX_W  = 8,
    parameter int HIST_W = 4
) (
    input  logic               clk,
    input  logic               rst,

    // apb slave
    input  logic               psel_i,
    input  logic               penable_i,
    input  logic               pwrite_i,
    input  bp_pkg::paddr_t     paddr_i,
    input  bp_pkg::word_t      pwdata_i,
    output bp_pkg::word_t      prdata_o,
    output logic               pready_o,

    // lookup
    input  bp_pkg::pc_t        pred_pc_i,
    output logic               pred_taken_o,

    // commit-time training
    input  logic               upd_valid_i,
    input  bp_pkg::pc_t        upd_pc_i,
    input  logic               upd_taken_i,
    input  logic               upd_pred_i
);

    bp_pkg::bp_mode_e mode;

    bp_csr csr_inst (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .mode_o       (mode),
        .upd_valid_i  (upd_valid_i),
        .upd_taken_i  (upd_taken_i),
        .upd_pred_i   (upd_pred_i)
    );

    tournament_predictor #(
        .IDX_W        (IDX_W),
        .HIST_W       (HIST_W)
    ) predictor_inst (
        .clk          (clk),
        .rst          (rst),
        .mode_i       (mode),
        .pred_pc_i    (pred_pc_i),
        .pred_taken_o (pred_taken_o),
        .upd_valid_i  (upd_valid_i),
        .upd_pc_i     (upd_pc_i),
        .upd_taken_i  (upd_taken_i)
    );

endmodule : bp_top

/* verif/bp_tb.sv */
`timescale 1ns/1ps

module bp_tb;

    localparam int READY_TIMEOUT = 16;

    logic               clk;
    logic               rst;
    logic               psel;
    logic               penable;
    logic               pwrite;
    bp_pkg::paddr_t     paddr;
    bp_pkg::word_t      pwdata;
    bp_pkg::word_t      prdata;
    logic               pready;
    bp_pkg::pc_t        pred_pc;
    logic               pred_taken;
    logic               upd_valid;
    bp_pkg::pc_t        upd_pc;
    logic               upd_taken;
    logic               upd_pred;

    // name of the test whose lines are being run
    logic [8*32-1:0]    cur_name;
    int                 test_errors;
    int                 pass_count;
    int                 fail_count;

    bp_top bp_top_inst (
        .clk          (clk),
        .rst          (rst),
        .psel_i       (psel),
        .penable_i    (penable),
        .pwrite_i     (pwrite),
        .paddr_i      (paddr),
        .pwdata_i     (pwdata),
        .prdata_o     (prdata),
        .pready_o     (pready),
        .pred_pc_i    (pred_pc),
        .pred_taken_o (pred_taken),
        .upd_valid_i  (upd_valid),
        .upd_pc_i     (upd_pc),
        .upd_taken_i  (upd_taken),
        .upd_pred_i   (upd_pred)
    );

    always #2 clk = ~clk;

    task automatic check_value(input bp_pkg::word_t expected, input bp_pkg::word_t actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %0s expected %h actual %h", cur_name, expected, actual);
            test_errors++;
        end
    endtask

    // setup cycle then access cycle until pready
    // pready and read data are sampled at the falling edge
    task automatic apb_transfer(input logic write, input bp_pkg::word_t addr,
                                input bp_pkg::word_t data, output bp_pkg::word_t rdata);
        int cycles;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= write;
        paddr   <= addr[7:0];
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        cycles = 0;
        @(negedge clk);
        while (!pready && cycles < READY_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!pready) begin
            $display("ERROR: pready never rose during an APB access in test %0s", cur_name);
            test_errors++;
        end
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    // the update trains at the edge that drops upd_valid
    task automatic do_update(input bp_pkg::pc_t pc, input logic taken, input logic pred);
        @(posedge clk);
        upd_valid <= 1'b1;
        upd_pc    <= pc;
        upd_taken <= taken;
        upd_pred  <= pred;
        @(posedge clk);
        upd_valid <= 1'b0;
    endtask

    task automatic check_prediction(input bp_pkg::pc_t pc, input logic expected);
        @(posedge clk);
        pred_pc <= pc;
        @(negedge clk);
        check_value({31'd0, expected}, {31'd0, pred_taken});
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            $display("test %0s passed", cur_name);
            pass_count++;
        end else begin
            $display("test %0s failed with %0d errors", cur_name, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    initial begin
        int                 fd;
        int                 n;
        logic [8*160-1:0]   line_buf;
        logic [8*32-1:0]    name_tok;
        logic [8*4-1:0]     op_tok;
        bp_pkg::word_t      arg_a;
        bp_pkg::word_t      arg_b;
        bp_pkg::word_t      arg_c;
        bp_pkg::word_t      rdata;
        clk = 1'b0;
        rst = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        pred_pc = '0;
        upd_valid = 1'b0;
        upd_pc = '0;
        upd_taken = 1'b0;
        upd_pred = 1'b0;
        cur_name = '0;
        test_errors = 0;
        pass_count = 0;
        fail_count = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        fd = $fopen("verif/bp_tests.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open verif/bp_tests.txt");
            fail_count++;
        end else begin
            while ($fgets(line_buf, fd) != 0) begin
                n = $sscanf(line_buf, "%s %s %h %h %h", name_tok, op_tok, arg_a, arg_b, arg_c);
                // blank lines and lines starting with # carry no operation
                if (n > 0 && name_tok != "#") begin
                    if (name_tok != cur_name) begin
                        if (cur_name != '0) begin
                            finish_test();
                        end
                        cur_name = name_tok;
                    end
                    if (n != 5) begin
                        $display("ERROR: test %0s has a line with missing fields", cur_name);
                        test_errors++;
                    end else begin
                        case (op_tok)
                            "W": apb_transfer(1'b1, arg_a, arg_b, rdata);
                            "R": begin
                                apb_transfer(1'b0, arg_a, 32'd0, rdata);
                                check_value(arg_b, rdata);
                            end
                            "U": do_update(arg_a, arg_b[0], arg_c[0]);
                            "P": check_prediction(arg_a, arg_b[0]);
                            default: begin
                                $display("ERROR: test %0s has an unknown operation", cur_name);
                                test_errors++;
                            end
                        endcase
                    end
                end
            end
            $fclose(fd);
            if (cur_name != '0) begin
                finish_test();
            end
        end

        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule : bp_tb

/* verif/bp_tests.txt */
# name op a b c, all values in hex
# W offset data 0 | R offset expected 0 | U pc taken pred | P pc expected 0
reset_state R 00 00000000 0
reset_state R 04 00000000 0
reset_state R 08 00000000 0
reset_state R 10 00000000 0
reset_state P 00000000 0 0
reset_state P 00000104 0 0
bimodal_train W 00 00000001 0
bimodal_train U 00000100 1 0
bimodal_train P 00000100 1 0
bimodal_train U 00000100 0 1
bimodal_train U 00000100 0 0
bimodal_train U 00000100 0 0
bimodal_train P 00000100 0 0
gselect_history W 00 00000002 0
gselect_history U 00000234 1 0
gselect_history P 00000234 0 0
gselect_history U 00000040 0 0
gselect_history U 00000040 0 0
gselect_history U 00000040 0 0
gselect_history P 00000234 1 0
tournament_choose W 00 00000000 0
tournament_choose U 00000368 1 0
tournament_choose P 00000368 1 0
tournament_choose U 00000368 0 1
tournament_choose U 00000040 0 0
tournament_choose U 00000040 0 0
tournament_choose P 00000368 1 0
tournament_mode3 W 00 00000003 0
tournament_mode3 R 00 00000003 0
tournament_mode3 P 00000368 1 0
tournament_mode3 U 00000040 0 0
tournament_mode3 P 00000234 1 0
stats_counts R 04 0000000d 0
stats_counts R 08 00000005 0
stats_clear W 0c 00000002 0
stats_clear R 04 0000000d 0
stats_clear W 0c 00000001 0
stats_clear R 04 00000000 0
stats_clear R 08 00000000 0
stats_clear U 00000080 1 0
stats_clear U 00000080 1 1
stats_clear R 04 00000002 0
stats_clear R 08 00000001 0
ctrl_readback W 00 00000002 0
ctrl_readback R 00 00000002 0

/* build.f */
common/bp_pkg.sv
bp_core/counter_table.sv
bp_core/tournament_predictor.sv
rtl/bp_csr.sv
rtl/bp_top.sv
verif/bp_tb.sv
